// File: project.f
+incdir+hdl
hdl/rcc_src_pkg.sv
hdl/rcc_div_pkg.sv
hdl/rcc_src_gate.sv
hdl/rcc_clk_switch_fsm.sv
hdl/rcc_clk_div.sv
hdl/rcc_pclk_timer_div.sv
hdl/rcc_sys_clk_gen.sv
test/rcc_clk_source.sv
test/tb_rcc_sys_clk_gen.sv

// File: run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator, then judge the log

rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 \
    --top-module tb_rcc_sys_clk_gen -f project.f \
    && ./obj_dir/Vtb_rcc_sys_clk_gen | tee sim.log \
    || echo "build or simulation ended with an error"

grep -qx "all tests passed" sim.log \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }

// File: test/tb_rcc_sys_clk_gen.sv
`timescale 1ns/1ns

`include "rcc_defs.svh"

// times of the last two rising edges of one clock
module edge_timer (
    input  logic   clk,
    output longint last_t,
    output longint prev_t
);

    longint last_q = -1;
    longint prev_q = -1;

    always @(posedge clk) begin
        prev_q <= last_q;
        last_q <= longint'($time);
    end

    assign last_t = last_q;
    assign prev_t = prev_q;

endmodule

module tb_rcc_sys_clk_gen;

    localparam int HSI_PER = 40;
    localparam int CSI_PER = 80;
    localparam int HSE_PER = 120;
    localparam int PLL_PER = 20;

    localparam int NUM_CFG        = 24;
    localparam int RESET_CYCLES   = 16;
    localparam int CFG_CYCLES     = 1200;
    localparam int WARM_CYCLES    = 600;
    localparam int SWITCH_LIMIT   = 200;
    localparam int TIMEOUT_CYCLES = NUM_CFG * 1400 + 200;
    localparam int SAMPLE_SKEW    = 5;
    localparam int NUM_MON        = 17;

    // slowest output that still shows two clean edges in the window
    localparam longint MAX_PERIOD = 6000;

    // outputs behind an inline latch gate stay low while gated
    localparam logic [NUM_MON-1:0] GATE_MASK = 17'h082A8;

    logic                   hsi_clk;
    logic                   csi_clk;
    logic                   hse_clk;
    logic                   pll1_p_clk;
    logic                   reset;
    logic [`RCC_SW_W-1:0]   sys_clk_sw;
    logic [`RCC_CPRE_W-1:0] d1cpre;
    logic [`RCC_CPRE_W-1:0] hpre;
    logic [`RCC_PPRE_W-1:0] d1ppre;
    logic [`RCC_PPRE_W-1:0] d2ppre1;
    logic [`RCC_PPRE_W-1:0] d2ppre2;
    logic [`RCC_PPRE_W-1:0] d3ppre;
    logic                   timpre;
    logic                   hrtimsel;
    logic                   c1_sleep;
    logic                   c1_deepsleep;
    logic                   c2_sleep;
    logic                   c2_deepsleep;
    logic                   d1_clk_arcg_en;
    logic                   d2_clk_arcg_en;
    logic                   sys_clk_arcg_en;
    logic                   rcc_d1_stop;
    logic                   rcc_d2_stop;
    logic                   rcc_sys_stop;

    logic                   sys_clk;
    logic [`RCC_SW_W-1:0]   sys_clk_sws;
    logic                   sys_d1cpre_clk;
    logic                   sys_hpre_clk;
    logic                   rcc_c1_clk;
    logic                   rcc_c1_systick_clk;
    logic                   rcc_c2_clk;
    logic                   rcc_c2_systick_clk;
    logic                   rcc_d1_bus_clk;
    logic                   rcc_apb3bridge_d1_clk;
    logic                   rcc_d2_bus_clk;
    logic                   rcc_apb1bridge_d2_clk;
    logic                   rcc_apb2bridge_d2_clk;
    logic                   rcc_timx_ker_clk;
    logic                   rcc_timy_ker_clk;
    logic                   rcc_hrtimer_prescalar_clk;
    logic                   rcc_d3_bus_clk;
    logic                   rcc_apb4bridge_d3_clk;

    logic [NUM_MON-1:0]     mon_clk;
    longint                 last_t [NUM_MON];
    longint                 prev_t [NUM_MON];
    longint                 exp_per [NUM_MON];
    string                  mon_name [NUM_MON] = '{
        "sys_clk", "sys_d1cpre_clk", "sys_hpre_clk", "rcc_c1_clk",
        "rcc_c1_systick_clk", "rcc_c2_clk", "rcc_c2_systick_clk",
        "rcc_d1_bus_clk", "rcc_apb3bridge_d1_clk", "rcc_d2_bus_clk",
        "rcc_apb1bridge_d2_clk", "rcc_apb2bridge_d2_clk", "rcc_timx_ker_clk",
        "rcc_timy_ker_clk", "rcc_hrtimer_prescalar_clk", "rcc_d3_bus_clk",
        "rcc_apb4bridge_d3_clk"
    };

    integer                 seed = 32'h94655ab9;
    int unsigned            cycle_cnt = 0;
    logic                   in_switch = 1'b0;
    longint                 phase_limit = 0;
    longint                 sys_edge_t = -1;

    rcc_clk_source #(
        .HSI_PER (HSI_PER),
        .CSI_PER (CSI_PER),
        .HSE_PER (HSE_PER),
        .PLL_PER (PLL_PER)
    ) u_clk_source (
        .hsi_clk    (hsi_clk),
        .csi_clk    (csi_clk),
        .hse_clk    (hse_clk),
        .pll1_p_clk (pll1_p_clk)
    );

    rcc_sys_clk_gen u_rcc_sys_clk_gen (
        .hsi_clk                   (hsi_clk),
        .csi_clk                   (csi_clk),
        .hse_clk                   (hse_clk),
        .pll1_p_clk                (pll1_p_clk),
        .reset                     (reset),
        .sys_clk_sw                (sys_clk_sw),
        .d1cpre                    (d1cpre),
        .hpre                      (hpre),
        .d1ppre                    (d1ppre),
        .d2ppre1                   (d2ppre1),
        .d2ppre2                   (d2ppre2),
        .d3ppre                    (d3ppre),
        .timpre                    (timpre),
        .hrtimsel                  (hrtimsel),
        .c1_sleep                  (c1_sleep),
        .c1_deepsleep              (c1_deepsleep),
        .c2_sleep                  (c2_sleep),
        .c2_deepsleep              (c2_deepsleep),
        .d1_clk_arcg_en            (d1_clk_arcg_en),
        .d2_clk_arcg_en            (d2_clk_arcg_en),
        .sys_clk_arcg_en           (sys_clk_arcg_en),
        .rcc_d1_stop               (rcc_d1_stop),
        .rcc_d2_stop               (rcc_d2_stop),
        .rcc_sys_stop              (rcc_sys_stop),
        .sys_clk                   (sys_clk),
        .sys_clk_sws               (sys_clk_sws),
        .sys_d1cpre_clk            (sys_d1cpre_clk),
        .sys_hpre_clk              (sys_hpre_clk),
        .rcc_c1_clk                (rcc_c1_clk),
        .rcc_c1_systick_clk        (rcc_c1_systick_clk),
        .rcc_c2_clk                (rcc_c2_clk),
        .rcc_c2_systick_clk        (rcc_c2_systick_clk),
        .rcc_d1_bus_clk            (rcc_d1_bus_clk),
        .rcc_apb3bridge_d1_clk     (rcc_apb3bridge_d1_clk),
        .rcc_d2_bus_clk            (rcc_d2_bus_clk),
        .rcc_apb1bridge_d2_clk     (rcc_apb1bridge_d2_clk),
        .rcc_apb2bridge_d2_clk     (rcc_apb2bridge_d2_clk),
        .rcc_timx_ker_clk          (rcc_timx_ker_clk),
        .rcc_timy_ker_clk          (rcc_timy_ker_clk),
        .rcc_hrtimer_prescalar_clk (rcc_hrtimer_prescalar_clk),
        .rcc_d3_bus_clk            (rcc_d3_bus_clk),
        .rcc_apb4bridge_d3_clk     (rcc_apb4bridge_d3_clk)
    );

    ////////////////////////////////////////////////////////////
    // period monitors
    ////////////////////////////////////////////////////////////

    // index 16 on the left down to index 0 on the right
    assign mon_clk = {rcc_apb4bridge_d3_clk, rcc_d3_bus_clk, rcc_hrtimer_prescalar_clk,
                      rcc_timy_ker_clk, rcc_timx_ker_clk, rcc_apb2bridge_d2_clk,
                      rcc_apb1bridge_d2_clk, rcc_d2_bus_clk, rcc_apb3bridge_d1_clk,
                      rcc_d1_bus_clk, rcc_c2_systick_clk, rcc_c2_clk,
                      rcc_c1_systick_clk, rcc_c1_clk, sys_hpre_clk,
                      sys_d1cpre_clk, sys_clk};

    for (genvar i = 0; i < NUM_MON; i++) begin : g_mon
        edge_timer u_edge_timer (
            .clk    (mon_clk[i]),
            .last_t (last_t[i]),
            .prev_t (prev_t[i])
        );
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("tests failed");
        $fatal(1, "stopped at the first failing check");
    endtask

    task automatic report_mismatch(input string sig, input longint exp_v, input longint act_v);
        report_failure($sformatf("mismatch at %0t: %s expected %0d actual %0d",
                                 $time, sig, exp_v, act_v));
    endtask

    // sys_clk phases while the source moves
    always @(sys_clk) begin
        if (in_switch && sys_edge_t >= 0) begin
            assert (longint'($time) - sys_edge_t >= phase_limit) else
                report_failure($sformatf("sys_clk phase of %0d ns ending at %0t is a glitch",
                                         longint'($time) - sys_edge_t, $time));
        end
        sys_edge_t = longint'($time);
    end

    always @(posedge hsi_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        assert (cycle_cnt < TIMEOUT_CYCLES) else
            report_failure("timeout: the run went past its cycle limit");
    end

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////

    function logic [31:0] rand_word();
        return $random(seed);
    endfunction

    // one in eight
    function logic rare_bit();
        logic [31:0] r;
        r = rand_word();
        return (r[2:0] == 3'd0);
    endfunction

    function automatic longint src_period(input logic [`RCC_SW_W-1:0] s);
        case (s)
            2'd0:    return longint'(HSI_PER);
            2'd1:    return longint'(CSI_PER);
            2'd2:    return longint'(HSE_PER);
            default: return longint'(PLL_PER);
        endcase
    endfunction

    // ahb-type code with ratio 32 skipped
    function automatic longint ahb_ratio(input logic [`RCC_CPRE_W-1:0] code);
        int n;
        if (!code[3]) begin
            n = 0;
        end else begin
            n = int'(code[2:0]) + 1;
            if (n >= 5) begin
                n = n + 1;
            end
        end
        return longint'(1) << n;
    endfunction

    function automatic longint apb_ratio(input logic [`RCC_PPRE_W-1:0] code);
        if (!code[2]) begin
            return 1;
        end else begin
            return longint'(2) << code[1:0];
        end
    endfunction

    // timer at 2x or 4x pclk but never above the bus clock
    function automatic longint timer_ratio(input logic [`RCC_PPRE_W-1:0] code, input logic tp);
        longint p;
        p = apb_ratio(code);
        if (p == 1) begin
            return 1;
        end else if (!tp) begin
            return p / 2;
        end else if (p >= 4) begin
            return p / 4;
        end else begin
            return 1;
        end
    endfunction

    task automatic build_model();
        longint src_p;
        longint cpre_p;
        longint hpre_p;
        logic   c1_on;
        logic   c2_on;
        logic   d1_on;
        logic   d2_on;
        logic   d3_on;
        src_p  = src_period(sys_clk_sw);
        cpre_p = src_p * ahb_ratio(d1cpre);
        hpre_p = cpre_p * ahb_ratio(hpre);
        c1_on  = !(c1_sleep || c1_deepsleep);
        c2_on  = !(c2_sleep || c2_deepsleep);
        d1_on  = rcc_d1_stop && d1_clk_arcg_en;
        d2_on  = rcc_d2_stop && d2_clk_arcg_en;
        d3_on  = !rcc_sys_stop && sys_clk_arcg_en;
        exp_per[0]  = src_p;
        exp_per[1]  = cpre_p;
        exp_per[2]  = hpre_p;
        exp_per[3]  = c1_on ? cpre_p : 0;
        exp_per[4]  = c1_on ? cpre_p * `RCC_SYSTICK_DIV : 0;
        exp_per[5]  = c2_on ? hpre_p : 0;
        exp_per[6]  = c2_on ? hpre_p * `RCC_SYSTICK_DIV : 0;
        exp_per[7]  = d1_on ? hpre_p : 0;
        exp_per[8]  = d1_on ? hpre_p * apb_ratio(d1ppre) : 0;
        exp_per[9]  = d2_on ? hpre_p : 0;
        exp_per[10] = d2_on ? hpre_p * apb_ratio(d2ppre1) : 0;
        exp_per[11] = d2_on ? hpre_p * apb_ratio(d2ppre2) : 0;
        exp_per[12] = d2_on ? hpre_p * timer_ratio(d2ppre1, timpre) : 0;
        exp_per[13] = d2_on ? hpre_p * timer_ratio(d2ppre2, timpre) : 0;
        exp_per[14] = hrtimsel ? exp_per[13] : exp_per[3];
        exp_per[15] = d3_on ? hpre_p : 0;
        exp_per[16] = d3_on ? hpre_p * apb_ratio(d3ppre) : 0;
    endtask

    function automatic longint max_period();
        longint m;
        m = 0;
        for (int i = 0; i < NUM_MON; i++) begin
            if (exp_per[i] > m) begin
                m = exp_per[i];
            end
        end
        return m;
    endfunction

    ////////////////////////////////////////////////////////////
    // stimulus and checks
    ////////////////////////////////////////////////////////////

    task automatic pick_config();
        logic [31:0] r;
        int          tries;
        r               = rand_word();
        sys_clk_sw      = r[1:0];
        timpre          = r[2];
        hrtimsel        = r[3];
        c1_sleep        = rare_bit();
        c1_deepsleep    = rare_bit();
        c2_sleep        = rare_bit();
        c2_deepsleep    = rare_bit();
        rcc_d1_stop     = !rare_bit();
        d1_clk_arcg_en  = !rare_bit();
        rcc_d2_stop     = !rare_bit();
        d2_clk_arcg_en  = !rare_bit();
        rcc_sys_stop    = rare_bit();
        sys_clk_arcg_en = !rare_bit();
        tries = 0;
        // redraw divides until every output fits the window
        do begin
            r       = rand_word();
            d1cpre  = r[3:0];
            hpre    = r[7:4];
            d1ppre  = r[10:8];
            d2ppre1 = r[13:11];
            d2ppre2 = r[16:14];
            d3ppre  = r[19:17];
            build_model();
            tries++;
        end while (max_period() > MAX_PERIOD && tries < 64);
        if (max_period() > MAX_PERIOD) begin
            d1cpre = '0;
            hpre   = '0;
            build_model();
        end
    endtask

    task automatic check_outputs(input longint mark, input longint quiet_from);
        longint per;
        for (int i = 0; i < NUM_MON; i++) begin
            if (exp_per[i] > 0) begin
                assert (prev_t[i] >= mark) else
                    report_failure($sformatf("%s gave fewer than two rising edges by %0t",
                                             mon_name[i], $time));
                per = last_t[i] - prev_t[i];
                assert (per == exp_per[i]) else
                    report_mismatch(mon_name[i], exp_per[i], per);
            end else begin
                assert (last_t[i] < quiet_from) else
                    report_failure($sformatf("%s rose at %0t while its clock was gated",
                                             mon_name[i], last_t[i]));
                if (GATE_MASK[i]) begin
                    assert (!mon_clk[i]) else
                        report_failure($sformatf("%s is high at %0t while gated",
                                                 mon_name[i], $time));
                end
            end
        end
        assert (sys_clk_sws == sys_clk_sw) else
            report_mismatch("sys_clk_sws", longint'(sys_clk_sw), longint'(sys_clk_sws));
    endtask

    initial begin
        longint mark;
        longint gate_mark;
        longint old_per;
        longint new_per;
        int     wait_cnt;
        reset           = 1'b1;
        sys_clk_sw      = '0;
        d1cpre          = '0;
        hpre            = '0;
        d1ppre          = '0;
        d2ppre1         = '0;
        d2ppre2         = '0;
        d3ppre          = '0;
        timpre          = 1'b0;
        hrtimsel        = 1'b0;
        c1_sleep        = 1'b0;
        c1_deepsleep    = 1'b0;
        c2_sleep        = 1'b0;
        c2_deepsleep    = 1'b0;
        d1_clk_arcg_en  = 1'b1;
        d2_clk_arcg_en  = 1'b1;
        sys_clk_arcg_en = 1'b1;
        rcc_d1_stop     = 1'b1;
        rcc_d2_stop     = 1'b1;
        rcc_sys_stop    = 1'b0;
        repeat (RESET_CYCLES) @(negedge hsi_clk);
        reset = 1'b0;

        for (int cfg = 0; cfg < NUM_CFG; cfg++) begin
            @(negedge hsi_clk);
            old_per = src_period(sys_clk_sw);
            pick_config();
            new_per = src_period(sys_clk_sw);
            phase_limit = ((old_per < new_per) ? old_per : new_per) / 2;
            in_switch = 1'b1;
            wait_cnt = 0;
            while (sys_clk_sws != sys_clk_sw && wait_cnt < SWITCH_LIMIT) begin
                @(negedge hsi_clk);
                wait_cnt++;
            end
            assert (sys_clk_sws == sys_clk_sw) else
                report_failure($sformatf("sys_clk_sws did not follow select %0d in time",
                                         sys_clk_sw));
            in_switch = 1'b0;

            // gated outputs stay quiet from here on
            @(negedge hsi_clk);
            gate_mark = longint'($time);

            // settle the divider chain before measuring
            repeat (WARM_CYCLES - 1) @(negedge hsi_clk);
            mark = longint'($time);
            repeat (CFG_CYCLES - WARM_CYCLES) @(negedge hsi_clk);
            #SAMPLE_SKEW;
            check_outputs(mark, gate_mark);
        end

        $display("all tests passed");
        $finish;
    end

endmodule

// File: test/rcc_clk_source.sv
`timescale 1ns/1ns

module rcc_clk_source #(
    parameter int HSI_PER = 40,
    parameter int CSI_PER = 80,
    parameter int HSE_PER = 120,
    parameter int PLL_PER = 20
) (
    output logic hsi_clk,
    output logic csi_clk,
    output logic hse_clk,
    output logic pll1_p_clk
);

    // all sources start low at time zero
    initial begin
        hsi_clk    = 1'b0;
        csi_clk    = 1'b0;
        hse_clk    = 1'b0;
        pll1_p_clk = 1'b0;
    end

    always #(HSI_PER / 2) hsi_clk = ~hsi_clk;

    always #(CSI_PER / 2) csi_clk = ~csi_clk;

    always #(HSE_PER / 2) hse_clk = ~hse_clk;

    always #(PLL_PER / 2) pll1_p_clk = ~pll1_p_clk;

endmodule

// File: hdl/rcc_sys_clk_gen.sv
`timescale 1ns/1ns

`include "rcc_defs.svh"

module rcc_sys_clk_gen
    import rcc_src_pkg::*;
    import rcc_div_pkg::*;
(
    input  logic                   hsi_clk,
    input  logic                   csi_clk,
    input  logic                   hse_clk,
    input  logic                   pll1_p_clk,
    input  logic                   reset,

    input  logic [`RCC_SW_W-1:0]   sys_clk_sw,

    input  logic [`RCC_CPRE_W-1:0] d1cpre,
    input  logic [`RCC_CPRE_W-1:0] hpre,
    input  logic [`RCC_PPRE_W-1:0] d1ppre,
    input  logic [`RCC_PPRE_W-1:0] d2ppre1,
    input  logic [`RCC_PPRE_W-1:0] d2ppre2,
    input  logic [`RCC_PPRE_W-1:0] d3ppre,
    input  logic                   timpre,
    input  logic                   hrtimsel,

    input  logic                   c1_sleep,
    input  logic                   c1_deepsleep,
    input  logic                   c2_sleep,
    input  logic                   c2_deepsleep,
    input  logic                   d1_clk_arcg_en,
    input  logic                   d2_clk_arcg_en,
    input  logic                   sys_clk_arcg_en,
    input  logic                   rcc_d1_stop,
    input  logic                   rcc_d2_stop,
    input  logic                   rcc_sys_stop,

    output logic                   sys_clk,
    output logic [`RCC_SW_W-1:0]   sys_clk_sws,
    output logic                   sys_d1cpre_clk,
    output logic                   sys_hpre_clk,
    output logic                   rcc_c1_clk,
    output logic                   rcc_c1_systick_clk,
    output logic                   rcc_c2_clk,
    output logic                   rcc_c2_systick_clk,
    output logic                   rcc_d1_bus_clk,
    output logic                   rcc_apb3bridge_d1_clk,
    output logic                   rcc_d2_bus_clk,
    output logic                   rcc_apb1bridge_d2_clk,
    output logic                   rcc_apb2bridge_d2_clk,
    output logic                   rcc_timx_ker_clk,
    output logic                   rcc_timy_ker_clk,
    output logic                   rcc_hrtimer_prescalar_clk,
    output logic                   rcc_d3_bus_clk,
    output logic                   rcc_apb4bridge_d3_clk
);

    localparam div_code_e SYSTICK_EXP = div_code_e'($clog2(`RCC_SYSTICK_DIV));

    // output clock gate slots
    localparam int G_C1 = 0;
    localparam int G_C2 = 1;
    localparam int G_D1 = 2;
    localparam int G_D2 = 3;
    localparam int G_D3 = 4;
    localparam int NUM_GATES = 5;

    logic [RCC_NUM_SRC-1:0] src_clk;
    logic [RCC_NUM_SRC-1:0] gate_req;
    logic [RCC_NUM_SRC-1:0] gate_ack;
    logic [RCC_NUM_SRC-1:0] src_gated;

    logic [NUM_GATES-1:0]   gate_src;
    logic [NUM_GATES-1:0]   gate_en;
    logic [NUM_GATES-1:0]   gate_lat;
    logic [NUM_GATES-1:0]   gate_out;

    ////////////////////////////////////////////////////////////
    // source switch
    ////////////////////////////////////////////////////////////

    // bit order follows the rcc_src_e encoding
    assign src_clk = {pll1_p_clk, hse_clk, csi_clk, hsi_clk};

    rcc_clk_switch_fsm u_switch_fsm (
        .hsi_clk     (hsi_clk),
        .reset       (reset),
        .sys_clk_sw  (rcc_src_e'(sys_clk_sw)),
        .gate_ack    (gate_ack),
        .gate_req    (gate_req),
        .sys_clk_sws (sys_clk_sws)
    );

    for (genvar i = 0; i < RCC_NUM_SRC; i++) begin : g_src_gate
        rcc_src_gate #(
            .RESET_ON (i == 0)
        ) u_src_gate (
            .src_clk  (src_clk[i]),
            .reset    (reset),
            .gate_req (gate_req[i]),
            .gate_clk (src_gated[i]),
            .gate_ack (gate_ack[i])
        );
    end

    // at most one gate is open outside a switch
    assign sys_clk = |src_gated;

    ////////////////////////////////////////////////////////////
    // core and ahb prescalers
    ////////////////////////////////////////////////////////////

    rcc_clk_div u_d1cpre_div (
        .clk_in  (sys_clk),
        .reset   (reset),
        .div_exp (decode_hpre(d1cpre)),
        .clk_out (sys_d1cpre_clk)
    );

    rcc_clk_div u_hpre_div (
        .clk_in  (sys_d1cpre_clk),
        .reset   (reset),
        .div_exp (decode_hpre(hpre)),
        .clk_out (sys_hpre_clk)
    );

    ////////////////////////////////////////////////////////////
    // enables and gates
    ////////////////////////////////////////////////////////////

    // d1 and d2 bus enables keep the stop-high-runs polarity
    assign gate_en[G_C1] = ~(c1_sleep | c1_deepsleep);
    assign gate_en[G_C2] = ~(c2_sleep | c2_deepsleep);
    assign gate_en[G_D1] = rcc_d1_stop & d1_clk_arcg_en;
    assign gate_en[G_D2] = rcc_d2_stop & d2_clk_arcg_en;
    assign gate_en[G_D3] = ~rcc_sys_stop & sys_clk_arcg_en;

    assign gate_src[G_C1] = sys_d1cpre_clk;
    assign gate_src[G_C2] = sys_hpre_clk;
    assign gate_src[G_D1] = sys_hpre_clk;
    assign gate_src[G_D2] = sys_hpre_clk;
    assign gate_src[G_D3] = sys_hpre_clk;

    for (genvar g = 0; g < NUM_GATES; g++) begin : g_clk_gate
        // enable held while the clock is high
        always_latch begin
            if (!gate_src[g]) begin
                gate_lat[g] <= gate_en[g];
            end
        end
        assign gate_out[g] = gate_src[g] & gate_lat[g];
    end

    assign rcc_c1_clk     = gate_out[G_C1];
    assign rcc_c2_clk     = gate_out[G_C2];
    assign rcc_d1_bus_clk = gate_out[G_D1];
    assign rcc_d2_bus_clk = gate_out[G_D2];
    assign rcc_d3_bus_clk = gate_out[G_D3];

    ////////////////////////////////////////////////////////////
    // systick and apb prescalers
    ////////////////////////////////////////////////////////////

    rcc_clk_div u_c1_systick_div (
        .clk_in  (rcc_c1_clk),
        .reset   (reset),
        .div_exp (SYSTICK_EXP),
        .clk_out (rcc_c1_systick_clk)
    );

    rcc_clk_div u_c2_systick_div (
        .clk_in  (rcc_c2_clk),
        .reset   (reset),
        .div_exp (SYSTICK_EXP),
        .clk_out (rcc_c2_systick_clk)
    );

    rcc_clk_div u_d1ppre_div (
        .clk_in  (rcc_d1_bus_clk),
        .reset   (reset),
        .div_exp (decode_ppre(d1ppre)),
        .clk_out (rcc_apb3bridge_d1_clk)
    );

    // apb1 and apb2 each carry a timer kernel clock
    rcc_pclk_timer_div u_apb1_timer_div (
        .clk_in      (rcc_d2_bus_clk),
        .reset       (reset),
        .div_sel     (d2ppre1),
        .timpre      (timpre),
        .pclk        (rcc_apb1bridge_d2_clk),
        .tim_ker_clk (rcc_timx_ker_clk)
    );

    rcc_pclk_timer_div u_apb2_timer_div (
        .clk_in      (rcc_d2_bus_clk),
        .reset       (reset),
        .div_sel     (d2ppre2),
        .timpre      (timpre),
        .pclk        (rcc_apb2bridge_d2_clk),
        .tim_ker_clk (rcc_timy_ker_clk)
    );

    rcc_clk_div u_d3ppre_div (
        .clk_in  (rcc_d3_bus_clk),
        .reset   (reset),
        .div_exp (decode_ppre(d3ppre)),
        .clk_out (rcc_apb4bridge_d3_clk)
    );

    // hrtimer from the apb2 timer clock or the core clock
    assign rcc_hrtimer_prescalar_clk = hrtimsel ? rcc_timy_ker_clk : rcc_c1_clk;

endmodule

// File: hdl/rcc_pclk_timer_div.sv
`timescale 1ns/1ns

`include "rcc_defs.svh"

module rcc_pclk_timer_div
    import rcc_div_pkg::*;
(
    input  logic                   clk_in,
    input  logic                   reset,
    input  logic [`RCC_PPRE_W-1:0] div_sel,
    input  logic                   timpre,
    output logic                   pclk,
    output logic                   tim_ker_clk
);

    div_code_e pclk_exp;
    div_code_e tim_exp;

    assign pclk_exp = decode_ppre(div_sel);

    // timer runs 2x or 4x pclk, capped at the bus clock
    always_comb begin
        if (timpre) begin
            tim_exp = (pclk_exp > div_2) ? div_code_e'(4'(pclk_exp) - 4'd2) : div_1;
        end else begin
            tim_exp = (pclk_exp > div_1) ? div_code_e'(4'(pclk_exp) - 4'd1) : div_1;
        end
    end

    rcc_clk_div u_pclk_div (
        .clk_in  (clk_in),
        .reset   (reset),
        .div_exp (pclk_exp),
        .clk_out (pclk)
    );

    rcc_clk_div u_tim_div (
        .clk_in  (clk_in),
        .reset   (reset),
        .div_exp (tim_exp),
        .clk_out (tim_ker_clk)
    );

endmodule

// File: hdl/rcc_clk_div.sv
`timescale 1ns/1ns

`include "rcc_defs.svh"

module rcc_clk_div
    import rcc_div_pkg::*;
(
    input  logic      clk_in,
    input  logic      reset,
    input  div_code_e div_exp,
    output logic      clk_out
);

    localparam int CNT_W = `RCC_DIV_MAX_LOG2;

    logic [CNT_W-1:0] cnt;
    logic [CNT_W-1:0] half_tc;
    logic             clk_div;

    // half period minus one, in input cycles
    always_comb begin
        half_tc = '0;
        if (div_exp != div_1) begin
            half_tc = (CNT_W'(1) << (4'(div_exp) - 4'd1)) - CNT_W'(1);
        end
    end

    ////////////////////////////////////////////////////////////
    // toggle counter
    ////////////////////////////////////////////////////////////

    // >= catches a code shrinking below the running count
    always_ff @(posedge clk_in) begin
        if (reset) begin
            cnt     <= '0;
            clk_div <= 1'b0;
        end else if (cnt >= half_tc) begin
            cnt     <= '0;
            clk_div <= ~clk_div;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // divide by one passes the input straight on
    assign clk_out = (div_exp == div_1) ? clk_in : clk_div;

endmodule

// File: hdl/rcc_clk_switch_fsm.sv
`timescale 1ns/1ns

module rcc_clk_switch_fsm
    import rcc_src_pkg::*;
(
    input  logic                   hsi_clk,
    input  logic                   reset,
    input  rcc_src_e               sys_clk_sw,
    input  logic [RCC_NUM_SRC-1:0] gate_ack,
    output logic [RCC_NUM_SRC-1:0] gate_req,
    output rcc_src_e               sys_clk_sws
);

    sw_state_e              state;
    rcc_src_e               cur_src;
    rcc_src_e               tgt_src;
    logic                   settle_cnt;
    logic [RCC_NUM_SRC-1:0] ack_meta;
    logic [RCC_NUM_SRC-1:0] ack_sync;

    ////////////////////////////////////////////////////////////
    // ack synchronizer
    ////////////////////////////////////////////////////////////

    // acks come from the four source domains
    always_ff @(posedge hsi_clk) begin
        if (reset) begin
            ack_meta <= RCC_HSI_ONLY;
            ack_sync <= RCC_HSI_ONLY;
        end else begin
            ack_meta <= gate_ack;
            ack_sync <= ack_meta;
        end
    end

    ////////////////////////////////////////////////////////////
    // break-before-make sequence
    ////////////////////////////////////////////////////////////

    always_ff @(posedge hsi_clk) begin
        if (reset) begin
            state      <= st_run;
            cur_src    <= src_hsi;
            tgt_src    <= src_hsi;
            gate_req   <= RCC_HSI_ONLY;
            settle_cnt <= 1'b0;
        end else begin
            case (state)
                st_run: begin
                    // select only sampled here, a late change waits its turn
                    if (sys_clk_sw != cur_src) begin
                        tgt_src           <= sys_clk_sw;
                        gate_req[cur_src] <= 1'b0;
                        state             <= st_drop_old;
                    end
                end
                st_drop_old: begin
                    // every gate closed before the new one opens
                    if (ack_sync == '0) begin
                        gate_req[tgt_src] <= 1'b1;
                        state             <= st_arm_new;
                    end
                end
                st_arm_new: begin
                    if (ack_sync[tgt_src]) begin
                        settle_cnt <= 1'b0;
                        state      <= st_settle;
                    end
                end
                st_settle: begin
                    // two hsi cycles before reporting
                    if (settle_cnt) begin
                        cur_src <= tgt_src;
                        state   <= st_run;
                    end else begin
                        settle_cnt <= 1'b1;
                    end
                end
                default: begin
                    state <= st_run;
                end
            endcase
        end
    end

    assign sys_clk_sws = cur_src;

endmodule

// File: hdl/rcc_src_gate.sv
`timescale 1ns/1ns

module rcc_src_gate #(
    parameter bit RESET_ON = 1'b0
) (
    input  logic src_clk,
    input  logic reset,
    input  logic gate_req,
    output logic gate_clk,
    output logic gate_ack
);

    logic req_meta;
    logic req_sync;
    logic en_lat;

    // request into the source domain
    always_ff @(posedge src_clk) begin
        if (reset) begin
            req_meta <= RESET_ON;
            req_sync <= RESET_ON;
        end else begin
            req_meta <= gate_req;
            req_sync <= req_meta;
        end
    end

    // open only while the source is low, so the enable moves on a falling edge
    always_latch begin
        if (!src_clk) begin
            en_lat <= req_sync;
        end
    end

    assign gate_clk = src_clk & en_lat;
    assign gate_ack = en_lat;

endmodule

// File: hdl/rcc_div_pkg.sv
package rcc_div_pkg;

`include "rcc_defs.svh"

    // value is the divide exponent
    typedef enum logic [3:0] {
        div_1   = 4'd0,
        div_2   = 4'd1,
        div_4   = 4'd2,
        div_8   = 4'd3,
        div_16  = 4'd4,
        div_32  = 4'd5,
        div_64  = 4'd6,
        div_128 = 4'd7,
        div_256 = 4'd8,
        div_512 = 4'd9
    } div_code_e;

    // ahb-type code, divide by 32 has no encoding
    function automatic div_code_e decode_hpre(input logic [`RCC_CPRE_W-1:0] code);
        div_code_e exp_val;
        if (!code[3]) begin
            exp_val = div_1;
        end else begin
            case (code[2:0])
                3'd0:    exp_val = div_2;
                3'd1:    exp_val = div_4;
                3'd2:    exp_val = div_8;
                3'd3:    exp_val = div_16;
                3'd4:    exp_val = div_64;
                3'd5:    exp_val = div_128;
                3'd6:    exp_val = div_256;
                default: exp_val = div_512;
            endcase
        end
        return exp_val;
    endfunction

    // apb-type code, up to divide by 16
    function automatic div_code_e decode_ppre(input logic [`RCC_PPRE_W-1:0] code);
        div_code_e exp_val;
        if (!code[2]) begin
            exp_val = div_1;
        end else begin
            case (code[1:0])
                2'd0:    exp_val = div_2;
                2'd1:    exp_val = div_4;
                2'd2:    exp_val = div_8;
                default: exp_val = div_16;
            endcase
        end
        return exp_val;
    endfunction

endpackage

// File: hdl/rcc_src_pkg.sv
package rcc_src_pkg;

`include "rcc_defs.svh"

    // sys_clk sources, encoded as the sw field
    typedef enum logic [`RCC_SW_W-1:0] {
        src_hsi    = 2'd0,
        src_csi    = 2'd1,
        src_hse    = 2'd2,
        src_pll1_p = 2'd3
    } rcc_src_e;

    localparam int RCC_NUM_SRC = 4;

    // only the hsi gate open out of reset
    localparam logic [RCC_NUM_SRC-1:0] RCC_HSI_ONLY = 4'b0001;

    // break-before-make switch states
    typedef enum logic [1:0] {
        st_run      = 2'd0,
        st_drop_old = 2'd1,
        st_arm_new  = 2'd2,
        st_settle   = 2'd3
    } sw_state_e;

endpackage

// File: hdl/rcc_defs.svh
`ifndef RCC_DEFS_SVH
`define RCC_DEFS_SVH

// width of the d1cpre and hpre codes
`define RCC_CPRE_W 4

// width of the apb-type prescaler codes
`define RCC_PPRE_W 3

// width of the sys_clk source select
`define RCC_SW_W 2

// largest divide exponent, divide by 512
// also sets the divider counter width
`define RCC_DIV_MAX_LOG2 9

// fixed core clock to systick ratio
`define RCC_SYSTICK_DIV 8

`endif
